/* common/ex_isa_pkg.sv */
package ex_isa_pkg;

    // execute-stage operation select, one word per op
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_NOR   = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_SLL   = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_LU12I = 4'd11,   // result is src2, decode supplies imm << 12
        ALU_MUL   = 4'd12,   // low word of product
        ALU_MULH  = 4'd13,   // signed high word
        ALU_MULHU = 4'd14    // unsigned high word
    } alu_op_e;

    // same encoding as data_sram_size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

/* common/ex_bus_pkg.sv */
package ex_bus_pkg;

    localparam int WORD_W  = 32;
    localparam int RF_AW   = 5;
    localparam int STRB_W  = WORD_W / 8;

    // data word or virtual address
    typedef logic [WORD_W-1:0]   word_t;

    // register file write address
    typedef logic [RF_AW-1:0]    rf_addr_t;

    // one bit per byte lane
    typedef logic [STRB_W-1:0]   wstrb_t;

    // full multiplier product
    typedef logic [2*WORD_W-1:0] dword_t;

endpackage

/* alu/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  ex_isa_pkg::alu_op_e alu_op,
    input  ex_bus_pkg::word_t   src1,
    input  ex_bus_pkg::word_t   src2,
    output ex_bus_pkg::word_t   alu_result,
    output logic                complete
);

    localparam int STEPS = 32 / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS) + 1;

    logic                          is_sub;
    ex_bus_pkg::word_t             adder_b;
    logic [32:0]                   add_sum;
    logic                          slt_res;
    logic                          is_mul;
    logic                          mul_signed;
    ex_bus_pkg::dword_t            acc;
    ex_bus_pkg::dword_t            mcand;
    ex_bus_pkg::word_t             mplier;
    logic [CNT_W-1:0]              cnt;
    logic                          mul_done;
    ex_bus_pkg::dword_t            cur_mcand;
    ex_bus_pkg::word_t             cur_mplier;
    ex_bus_pkg::dword_t            acc_base;
    logic [MUL_BITS_PER_CYCLE-1:0] chunk;
    logic                          last_step;
    ex_bus_pkg::dword_t            pp;

    if (MUL_BITS_PER_CYCLE != 1 && MUL_BITS_PER_CYCLE != 2 &&
        MUL_BITS_PER_CYCLE != 4 && MUL_BITS_PER_CYCLE != 8) begin : g_bad_param
        $error("alu: MUL_BITS_PER_CYCLE must be 1, 2, 4 or 8");
    end

    // shared adder for add/sub/compare
    assign is_sub  = alu_op inside {ex_isa_pkg::ALU_SUB, ex_isa_pkg::ALU_SLT,
                                    ex_isa_pkg::ALU_SLTU};
    assign adder_b = is_sub ? ~src2 : src2;
    assign add_sum = {1'b0, src1} + {1'b0, adder_b} + {32'd0, is_sub};
    assign slt_res = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & add_sum[31]);

    always_comb begin
        case (alu_op)
            ex_isa_pkg::ALU_ADD,
            ex_isa_pkg::ALU_SUB:   alu_result = add_sum[31:0];
            ex_isa_pkg::ALU_SLT:   alu_result = {31'd0, slt_res};
            ex_isa_pkg::ALU_SLTU:  alu_result = {31'd0, ~add_sum[32]};  // borrow out
            ex_isa_pkg::ALU_AND:   alu_result = src1 & src2;
            ex_isa_pkg::ALU_OR:    alu_result = src1 | src2;
            ex_isa_pkg::ALU_NOR:   alu_result = ~(src1 | src2);
            ex_isa_pkg::ALU_XOR:   alu_result = src1 ^ src2;
            ex_isa_pkg::ALU_SLL:   alu_result = src1 << src2[4:0];
            ex_isa_pkg::ALU_SRL:   alu_result = src1 >> src2[4:0];
            ex_isa_pkg::ALU_SRA:   alu_result = $signed(src1) >>> src2[4:0];
            ex_isa_pkg::ALU_LU12I: alu_result = src2;
            ex_isa_pkg::ALU_MUL:   alu_result = acc[31:0];
            ex_isa_pkg::ALU_MULH,
            ex_isa_pkg::ALU_MULHU: alu_result = acc[63:32];
            default:               alu_result = '0;
        endcase
    end

    assign is_mul     = alu_op inside {ex_isa_pkg::ALU_MUL, ex_isa_pkg::ALU_MULH,
                                       ex_isa_pkg::ALU_MULHU};
    assign mul_signed = (alu_op == ex_isa_pkg::ALU_MULH);

    // first step works straight from the operands
    assign cur_mcand  = start ? {{32{mul_signed & src1[31]}}, src1} : mcand;
    assign cur_mplier = start ? src2 : mplier;
    assign acc_base   = start ? ex_bus_pkg::dword_t'(0) : acc;
    assign chunk      = cur_mplier[MUL_BITS_PER_CYCLE-1:0];
    assign last_step  = start ? (STEPS == 1) : (cnt == CNT_W'(1));

    always_comb begin
        pp = cur_mcand * ex_bus_pkg::dword_t'(chunk);
        // top bit of src2 carries negative weight for mulh
        if (mul_signed && last_step && chunk[MUL_BITS_PER_CYCLE-1]) begin
            pp = pp - (cur_mcand << MUL_BITS_PER_CYCLE);
        end
    end

    always_ff @(posedge clk) begin
        if (start || cnt != '0) begin
            acc    <= acc_base + pp;
            mcand  <= cur_mcand << MUL_BITS_PER_CYCLE;
            mplier <= cur_mplier >> MUL_BITS_PER_CYCLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt      <= '0;
            mul_done <= 1'b0;
        end else if (start) begin
            cnt      <= CNT_W'(STEPS - 1);
            mul_done <= (STEPS == 1);
        end else if (cnt != '0) begin
            cnt      <= cnt - 1'b1;
            mul_done <= (cnt == CNT_W'(1));  // last chunk retired
        end
    end

    assign complete = is_mul ? (mul_done & ~start) : 1'b1;

    // result may only be withdrawn by a new load
    a_complete_held: assert property (@(posedge clk) disable iff (!resetn)
        $fell(complete) |-> start)
        else $error("alu: complete dropped without start");

endmodule

/* logic/agu.sv */
`timescale 1ns/1ps

module agu (
    input  ex_bus_pkg::word_t     src1,
    input  ex_bus_pkg::word_t     src2,
    input  ex_bus_pkg::word_t     rkd_value,
    input  ex_isa_pkg::mem_size_e mem_size,
    input  logic                  mem_access,
    output ex_bus_pkg::word_t     vaddr,
    output ex_bus_pkg::wstrb_t    wstrb,
    output ex_bus_pkg::word_t     wdata,
    output logic                  ale
);

    logic [1:0] offset;
    logic       half_mis;
    logic       word_mis;

    // own adder so the address does not wait on the alu mux
    assign vaddr  = src1 + src2;
    assign offset = vaddr[1:0];

    always_comb begin
        case (mem_size)
            ex_isa_pkg::SIZE_BYTE: begin
                wdata = {4{rkd_value[7:0]}};    // byte in every lane
                wstrb = 4'b0001 << offset;
            end
            ex_isa_pkg::SIZE_HALF: begin
                wdata = {2{rkd_value[15:0]}};
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
            end
            ex_isa_pkg::SIZE_WORD: begin
                wdata = rkd_value;
                wstrb = 4'b1111;
            end
            default: begin
                wdata = rkd_value;
                wstrb = 4'b0000;                // unused size code
            end
        endcase
    end

    assign half_mis = (mem_size == ex_isa_pkg::SIZE_HALF) & offset[0];
    assign word_mis = (mem_size == ex_isa_pkg::SIZE_WORD) & (|offset);
    assign ale      = mem_access & (half_mis | word_mis);

endmodule

/* logic/ex_pipe_ctrl.sv */
`timescale 1ns/1ps

module ex_pipe_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    // from decode
    input  logic                  id_to_ex_valid,
    output logic                  ex_allowin,
    input  ex_bus_pkg::word_t     pc,
    input  ex_isa_pkg::alu_op_e   alu_op,
    input  ex_bus_pkg::word_t     src1,
    input  ex_bus_pkg::word_t     src2,
    input  ex_bus_pkg::word_t     rkd_value,
    input  logic                  rf_we,
    input  ex_bus_pkg::rf_addr_t  rf_waddr,
    input  logic                  mem_re,
    input  logic                  mem_we,
    input  ex_isa_pkg::mem_size_e mem_size,
    input  logic                  mem_unsigned,
    input  logic                  flush,
    // to memory stage
    input  logic                  mem_allowin,
    output logic                  ex_to_mem_valid,
    output ex_bus_pkg::word_t     ex_pc,
    output ex_bus_pkg::word_t     ex_result,
    output logic                  ex_rf_we,
    output ex_bus_pkg::rf_addr_t  ex_rf_waddr,
    output logic                  ex_res_from_mem,
    output logic                  ex_mem_unsigned,
    output logic [1:0]            ex_byte_offset,
    output logic                  ex_excep_ale,
    // data sram
    output logic                  data_sram_req,
    output logic                  data_sram_wr,
    output logic [1:0]            data_sram_size,
    output ex_bus_pkg::wstrb_t    data_sram_wstrb,
    output ex_bus_pkg::word_t     data_sram_addr,
    output ex_bus_pkg::word_t     data_sram_wdata,
    input  logic                  data_sram_addr_ok,
    // alu and agu
    output logic                  alu_start,
    output ex_isa_pkg::alu_op_e   lat_alu_op,
    output ex_bus_pkg::word_t     lat_src1,
    output ex_bus_pkg::word_t     lat_src2,
    output ex_bus_pkg::word_t     lat_rkd_value,
    output ex_isa_pkg::mem_size_e lat_mem_size,
    output logic                  lat_mem_access,
    input  ex_bus_pkg::word_t     alu_result,
    input  logic                  complete,
    input  ex_bus_pkg::word_t     vaddr,
    input  ex_bus_pkg::wstrb_t    wstrb,
    input  ex_bus_pkg::word_t     wdata,
    input  logic                  ale
);

    logic                 ex_valid;
    logic                 load;
    logic                 mem_req;
    logic                 ready_go;
    ex_bus_pkg::word_t    lat_pc;
    ex_bus_pkg::rf_addr_t lat_rf_waddr;
    logic                 lat_rf_we;
    logic                 lat_mem_re;
    logic                 lat_mem_we;
    logic                 lat_mem_unsigned;

    assign load = id_to_ex_valid & ex_allowin & ~flush;  // flushed transfer is dropped

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid   <= 1'b0;
            alu_start  <= 1'b0;
            lat_alu_op <= ex_isa_pkg::ALU_ADD;
            lat_rf_we  <= 1'b0;
            lat_mem_re <= 1'b0;
            lat_mem_we <= 1'b0;
        end else begin
            alu_start <= load;                            // one cycle, first valid cycle
            if (flush) begin
                ex_valid <= 1'b0;
            end else if (ex_allowin) begin
                ex_valid <= id_to_ex_valid;
            end
            if (load) begin
                lat_alu_op <= alu_op;
                lat_rf_we  <= rf_we;
                lat_mem_re <= mem_re;
                lat_mem_we <= mem_we;
            end
        end
    end

    // operands and payload
    always_ff @(posedge clk) begin
        if (load) begin
            lat_pc           <= pc;
            lat_src1         <= src1;
            lat_src2         <= src2;
            lat_rkd_value    <= rkd_value;
            lat_rf_waddr     <= rf_waddr;
            lat_mem_size     <= mem_size;
            lat_mem_unsigned <= mem_unsigned;
        end
    end

    assign lat_mem_access = lat_mem_re | lat_mem_we;

    // ale and flush kill the access before it reaches the sram
    assign mem_req  = ex_valid & lat_mem_access & ~ale & ~flush;
    assign ready_go = complete & (~mem_req | data_sram_addr_ok);

    assign ex_allowin      = ~ex_valid | (ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ready_go & ~flush;

    assign data_sram_req   = mem_req & mem_allowin;          // withdrawn under back-pressure
    assign data_sram_wr    = lat_mem_we;
    assign data_sram_size  = lat_mem_size;
    assign data_sram_wstrb = {4{lat_mem_we}} & wstrb;
    assign data_sram_addr  = vaddr;
    assign data_sram_wdata = wdata;

    assign ex_pc           = lat_pc;
    assign ex_result       = lat_mem_access ? vaddr : alu_result;
    assign ex_rf_we        = lat_rf_we & ex_valid;
    assign ex_rf_waddr     = lat_rf_waddr;
    assign ex_res_from_mem = lat_mem_re & ex_valid;
    assign ex_mem_unsigned = lat_mem_unsigned;
    assign ex_byte_offset  = vaddr[1:0];
    assign ex_excep_ale    = ale;

    // an outstanding request keeps its instruction in the stage
    a_req_valid: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_req && !data_sram_addr_ok |=> ex_valid)
        else $error("ex_pipe_ctrl: stage emptied while sram request pending");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(resetn) |-> !ex_to_mem_valid)
        else $error("ex_pipe_ctrl: hand-off right after reset");

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
    parameter int MUL_BITS_PER_CYCLE = 4
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_to_ex_valid,
    output logic                  ex_allowin,
    input  ex_bus_pkg::word_t     pc,
    input  ex_isa_pkg::alu_op_e   alu_op,
    input  ex_bus_pkg::word_t     src1,
    input  ex_bus_pkg::word_t     src2,
    input  ex_bus_pkg::word_t     rkd_value,
    input  logic                  rf_we,
    input  ex_bus_pkg::rf_addr_t  rf_waddr,
    input  logic                  mem_re,
    input  logic                  mem_we,
    input  ex_isa_pkg::mem_size_e mem_size,
    input  logic                  mem_unsigned,
    input  logic                  flush,
    input  logic                  mem_allowin,
    output logic                  ex_to_mem_valid,
    output ex_bus_pkg::word_t     ex_pc,
    output ex_bus_pkg::word_t     ex_result,
    output logic                  ex_rf_we,
    output ex_bus_pkg::rf_addr_t  ex_rf_waddr,
    output logic                  ex_res_from_mem,
    output logic                  ex_mem_unsigned,
    output logic [1:0]            ex_byte_offset,
    output logic                  ex_excep_ale,
    output logic                  data_sram_req,
    output logic                  data_sram_wr,
    output logic [1:0]            data_sram_size,
    output ex_bus_pkg::wstrb_t    data_sram_wstrb,
    output ex_bus_pkg::word_t     data_sram_addr,
    output ex_bus_pkg::word_t     data_sram_wdata,
    input  logic                  data_sram_addr_ok
);

    logic                  alu_start;
    ex_isa_pkg::alu_op_e   lat_alu_op;
    ex_bus_pkg::word_t     lat_src1;
    ex_bus_pkg::word_t     lat_src2;
    ex_bus_pkg::word_t     lat_rkd_value;
    ex_isa_pkg::mem_size_e lat_mem_size;
    logic                  lat_mem_access;
    ex_bus_pkg::word_t     alu_result;
    logic                  complete;
    ex_bus_pkg::word_t     vaddr;
    ex_bus_pkg::wstrb_t    wstrb;
    ex_bus_pkg::word_t     wdata;
    logic                  ale;

    ex_pipe_ctrl u_ctrl (.*);   // every port shares its name with a top port or net

    alu #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_alu (
        .clk        (clk),
        .resetn     (resetn),
        .start      (alu_start),
        .alu_op     (lat_alu_op),
        .src1       (lat_src1),
        .src2       (lat_src2),
        .alu_result (alu_result),
        .complete   (complete)
    );

    // address path runs beside the alu on the same operands
    agu u_agu (
        .src1       (lat_src1),
        .src2       (lat_src2),
        .rkd_value  (lat_rkd_value),
        .mem_size   (lat_mem_size),
        .mem_access (lat_mem_access),
        .vaddr      (vaddr),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .ale        (ale)
    );

endmodule

/* bench/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int MUL_BITS       = 4;
    localparam int MUL_STEPS      = 32 / MUL_BITS;
    localparam int TIMEOUT_CYCLES = 4000;  // tests need well under 1000 cycles

    logic                  clk;
    logic                  resetn;
    logic                  id_to_ex_valid;
    logic                  ex_allowin;
    ex_bus_pkg::word_t     pc;
    ex_isa_pkg::alu_op_e   alu_op;
    ex_bus_pkg::word_t     src1;
    ex_bus_pkg::word_t     src2;
    ex_bus_pkg::word_t     rkd_value;
    logic                  rf_we;
    ex_bus_pkg::rf_addr_t  rf_waddr;
    logic                  mem_re;
    logic                  mem_we;
    ex_isa_pkg::mem_size_e mem_size;
    logic                  mem_unsigned;
    logic                  flush;
    logic                  mem_allowin;
    logic                  ex_to_mem_valid;
    ex_bus_pkg::word_t     ex_pc;
    ex_bus_pkg::word_t     ex_result;
    logic                  ex_rf_we;
    ex_bus_pkg::rf_addr_t  ex_rf_waddr;
    logic                  ex_res_from_mem;
    logic                  ex_mem_unsigned;
    logic [1:0]            ex_byte_offset;
    logic                  ex_excep_ale;
    logic                  data_sram_req;
    logic                  data_sram_wr;
    logic [1:0]            data_sram_size;
    ex_bus_pkg::wstrb_t    data_sram_wstrb;
    ex_bus_pkg::word_t     data_sram_addr;
    ex_bus_pkg::word_t     data_sram_wdata;
    logic                  data_sram_addr_ok;

    logic [31:0] lfsr = 32'h7861;
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    // values captured by the hand-off monitor
    int lat_q, delay_q;
    logic req_seen, ale_q, wr_q;
    logic rf_we_q, from_mem_q, unsigned_q;
    logic [1:0] size_q, offset_q;
    ex_bus_pkg::rf_addr_t waddr_q;
    ex_bus_pkg::wstrb_t wstrb_q;
    ex_bus_pkg::word_t res_q, pc_q, addr_q, wdata_q;

    ex_stage #(.MUL_BITS_PER_CYCLE(MUL_BITS)) ex_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic ex_bus_pkg::word_t rand_bits(input int n);
        ex_bus_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic ex_bus_pkg::word_t ref_alu(input ex_isa_pkg::alu_op_e op,
                                                   input ex_bus_pkg::word_t a, b);
        logic [63:0]        prod_u;
        logic signed [63:0] prod_s;
        prod_u = {32'd0, a} * {32'd0, b};
        prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            ex_isa_pkg::ALU_ADD:   return a + b;
            ex_isa_pkg::ALU_SUB:   return a - b;
            ex_isa_pkg::ALU_SLT:   return {31'd0, $signed(a) < $signed(b)};
            ex_isa_pkg::ALU_SLTU:  return {31'd0, a < b};
            ex_isa_pkg::ALU_AND:   return a & b;
            ex_isa_pkg::ALU_OR:    return a | b;
            ex_isa_pkg::ALU_NOR:   return ~(a | b);
            ex_isa_pkg::ALU_XOR:   return a ^ b;
            ex_isa_pkg::ALU_SLL:   return a << b[4:0];
            ex_isa_pkg::ALU_SRL:   return a >> b[4:0];
            ex_isa_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
            ex_isa_pkg::ALU_LU12I: return b;
            ex_isa_pkg::ALU_MUL:   return prod_u[31:0];
            ex_isa_pkg::ALU_MULH:  return prod_s[63:32];
            ex_isa_pkg::ALU_MULHU: return prod_u[63:32];
            default:               return '0;
        endcase
    endfunction

    task automatic check_val(input string name, input ex_bus_pkg::word_t got, exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // fields that ride through the stage register unchanged
    task automatic check_payload();
        check_val("ex_pc", pc_q, pc);
        check_val("ex_rf_we", rf_we_q, rf_we);
        check_val("ex_rf_waddr", waddr_q, rf_waddr);
        check_val("ex_res_from_mem", from_mem_q, mem_re);
        check_val("ex_mem_unsigned", unsigned_q, mem_unsigned);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%s: %s (%0d errors)", name, (errors == errs_before) ? "ok" : "failed",
                 errors - errs_before);
    endtask

    task automatic issue(input ex_isa_pkg::alu_op_e op, input ex_bus_pkg::word_t a, b,
                         input logic re, we, input int size);
        @(negedge clk);
        data_sram_addr_ok = 1'b0;
        id_to_ex_valid    = 1'b1;
        pc           = rand_bits(30) << 2;
        alu_op       = op;
        src1         = a;
        src2         = b;
        rkd_value    = rand_bits(32);
        rf_we        = ~we;
        rf_waddr     = 5'(rand_bits(5));
        mem_re       = re;
        mem_we       = we;
        mem_size     = ex_isa_pkg::mem_size_e'(size);
        mem_unsigned = 1'(rand_bits(1));
        #1;
        while (!ex_allowin) begin          // wait for the transfer edge
            @(negedge clk);
            #1;
        end
    endtask

    // also acts as sram responder, acking after 0..3 cycles of request
    task automatic run_until_handoff();
        int n;
        int waited;
        n        = 0;
        waited   = 0;
        lat_q    = -1;
        req_seen = 1'b0;
        delay_q  = int'(rand_bits(2));
        while (lat_q < 0 && n < 64) begin
            @(negedge clk);
            id_to_ex_valid    = 1'b0;
            data_sram_addr_ok = 1'b0;
            if (data_sram_req) begin
                if (!req_seen) begin
                    size_q  = data_sram_size;
                    wstrb_q = data_sram_wstrb;
                    wdata_q = data_sram_wdata;
                    addr_q  = data_sram_addr;
                    wr_q    = data_sram_wr;
                end
                req_seen          = 1'b1;
                data_sram_addr_ok = (waited == delay_q);
                waited++;
            end else begin
                check_true(!req_seen, "sram request withdrawn before addr_ok");
            end
            #1;
            if (ex_to_mem_valid && mem_allowin) begin
                lat_q      = n;
                res_q      = ex_result;
                ale_q      = ex_excep_ale;
                pc_q       = ex_pc;
                rf_we_q    = ex_rf_we;
                waddr_q    = ex_rf_waddr;
                from_mem_q = ex_res_from_mem;
                unsigned_q = ex_mem_unsigned;
                offset_q   = ex_byte_offset;
            end
            n++;
        end
        check_true(lat_q >= 0, "no hand-off to memory stage within 64 cycles");
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            data_sram_addr_ok = 1'b0;
            #1;
            check_true(!ex_to_mem_valid && !data_sram_req && ex_allowin, "stage not idle");
            check_true(!ex_rf_we && !ex_res_from_mem, "write enables active in empty stage");
        end
    endtask

    task automatic reset_and_alu_test();
        int e0;
        ex_bus_pkg::word_t a, b;
        ex_isa_pkg::alu_op_e op;
        e0 = errors;
        check_true(ex_allowin && !data_sram_req && !ex_to_mem_valid, "stage busy after reset");
        for (int i = 0; i <= 11; i++) begin
            op = ex_isa_pkg::alu_op_e'(i);
            a  = rand_bits(32);
            b  = rand_bits(32);
            issue(op, a, b, 1'b0, 1'b0, 2);
            run_until_handoff();
            check_val("latency", lat_q, 0);
            check_val("ex_result", res_q, ref_alu(op, a, b));
            check_payload();
        end
        report_test("alu_ops", e0);
    endtask

    task automatic mul_test();
        int e0;
        ex_bus_pkg::word_t a, b;
        ex_isa_pkg::alu_op_e op;
        e0 = errors;
        for (int i = 0; i < 9; i++) begin
            op = ex_isa_pkg::alu_op_e'(12 + i % 3);
            a  = (i < 3) ? 32'h8000_0000 : rand_bits(32);   // most negative times -1 first
            b  = (i < 3) ? 32'hffff_ffff : rand_bits(32);
            issue(op, a, b, 1'b0, 1'b0, 2);
            run_until_handoff();
            check_val("latency", lat_q, MUL_STEPS);
            check_val("ex_result", res_q, ref_alu(op, a, b));
            check_payload();
        end
        report_test("multiply", e0);
    endtask

    task automatic store_test();
        int e0;
        ex_bus_pkg::word_t base, exp_data;
        ex_bus_pkg::wstrb_t exp_strb;
        e0 = errors;
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off += (1 << sz)) begin
                base = rand_bits(32) & ~32'd3;
                issue(ex_isa_pkg::ALU_ADD, base, off, 1'b0, 1'b1, sz);
                run_until_handoff();
                case (sz)
                    0: begin
                        exp_strb = 4'b0001 << off;
                        exp_data = {4{rkd_value[7:0]}};
                    end
                    1: begin
                        exp_strb = 4'b0011 << off;
                        exp_data = {2{rkd_value[15:0]}};
                    end
                    default: begin
                        exp_strb = 4'b1111;
                        exp_data = rkd_value;
                    end
                endcase
                check_true(req_seen && wr_q, "store issued no sram write request");
                check_val("data_sram_size", size_q, sz);
                check_val("data_sram_wstrb", wstrb_q, exp_strb);
                check_val("data_sram_wdata", wdata_q, exp_data);
                check_val("data_sram_addr", addr_q, base + off);
                check_val("ex_result", res_q, base + off);
                check_val("ex_byte_offset", offset_q, off);
                check_val("latency", lat_q, delay_q);     // hand-off in the addr_ok cycle
                check_payload();
            end
        end
        report_test("stores", e0);
    endtask

    task automatic ale_test();
        int e0;
        ex_bus_pkg::word_t base;
        e0 = errors;
        for (int sz = 1; sz < 3; sz++) begin
            for (int off = 1; off < 4; off++) begin
                if (!(sz == 1 && off == 2)) begin
                    base = rand_bits(32) & ~32'd3;
                    issue(ex_isa_pkg::ALU_ADD, base, off, off[0], ~off[0], sz);
                    run_until_handoff();
                    check_true(!req_seen, "misaligned access issued an sram request");
                    check_val("ex_excep_ale", ale_q, 1);
                    check_val("ex_result", res_q, base + off);
                    check_val("ex_byte_offset", offset_q, off);
                    check_val("latency", lat_q, 0);
                    check_payload();
                end
            end
        end
        check_idle(2);                           // last access was a load with rf_we set
        report_test("misaligned", e0);
    endtask

    task automatic backpressure_test();
        int e0;
        ex_bus_pkg::word_t base, snap_res, snap_addr, snap_data;
        e0 = errors;
        @(negedge clk);
        mem_allowin = 1'b0;
        base = rand_bits(32) & ~32'd3;
        issue(ex_isa_pkg::ALU_ADD, base, 32'd0, 1'b0, 1'b1, 2);
        @(negedge clk);
        id_to_ex_valid = 1'b0;
        #1;
        snap_res  = ex_result;
        snap_addr = data_sram_addr;
        snap_data = data_sram_wdata;
        repeat (6) begin
            check_true(!ex_allowin && !data_sram_req && !ex_to_mem_valid,
                       "stage not stalled while memory stage blocks");
            check_val("ex_result", ex_result, snap_res);
            check_val("data_sram_addr", data_sram_addr, snap_addr);
            check_val("data_sram_wdata", data_sram_wdata, snap_data);
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        mem_allowin = 1'b1;
        run_until_handoff();
        check_val("ex_result", res_q, snap_res);
        check_payload();
        check_idle(3);                           // no second hand-off
        report_test("backpressure", e0);
    endtask

    task automatic flush_test();
        int e0;
        e0 = errors;
        issue(ex_isa_pkg::ALU_ADD, rand_bits(32) & ~32'd3, 32'd0, 1'b0, 1'b1, 2);
        @(negedge clk);
        id_to_ex_valid = 1'b0;
        #1;
        check_true(data_sram_req, "store issued no sram request");
        @(negedge clk);
        flush = 1'b1;
        #1;
        check_true(!data_sram_req && !ex_to_mem_valid, "flushed instruction still active");
        @(negedge clk);
        flush = 1'b0;
        #1;
        check_true(ex_allowin && !ex_to_mem_valid, "stage not empty after flush");
        check_idle(2);
        report_test("flush", e0);
    endtask

    initial begin
        resetn            = 1'b0;
        id_to_ex_valid    = 1'b0;
        pc                = '0;
        alu_op            = ex_isa_pkg::ALU_ADD;
        src1              = '0;
        src2              = '0;
        rkd_value         = '0;
        rf_we             = 1'b0;
        rf_waddr          = '0;
        mem_re            = 1'b0;
        mem_we            = 1'b0;
        mem_size          = ex_isa_pkg::SIZE_WORD;
        mem_unsigned      = 1'b0;
        flush             = 1'b0;
        mem_allowin       = 1'b1;
        data_sram_addr_ok = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        #1;
        reset_and_alu_test();
        mul_test();
        store_test();
        ale_test();
        backpressure_test();
        flush_test();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
common/ex_isa_pkg.sv
common/ex_bus_pkg.sv
alu/alu.sv
logic/agu.sv
logic/ex_pipe_ctrl.sv
logic/ex_stage.sv
bench/tb_ex_stage.sv
